/* hdl/mmu_pkg.sv */
package mmu_pkg;

    // widths seen on the core and memory sides
    typedef logic [31:0] vaddr_t;   // virtual address from the core
    typedef logic [31:0] paddr_t;   // physical address to the targets
    typedef logic [31:0] word_t;    // data or instruction word
    typedef logic [3:0]  strb_t;    // byte write enable, one bit per byte

    // cacheability code of kseg0, same encoding as the Config.K0 field
    typedef logic [2:0]  k0_t;

    // top three address bits select the segment
    typedef logic [2:0]  seg_t;

    localparam k0_t K0_UNCACHED       = 3'd2;
    localparam k0_t K0_CACHED_DEFAULT = 3'd3;  // cacheable, noncoherent

    // unmapped segments, both fold onto the low 512 MB
    localparam seg_t SEG_KSEG0 = 3'b100;  // 0x8000_0000..0x9fff_ffff
    localparam seg_t SEG_KSEG1 = 3'b101;  // 0xa000_0000..0xbfff_ffff

endpackage

/* hdl/addr_translate.sv */
`timescale 1ns/10ps

module addr_translate #(
    parameter mmu_pkg::k0_t K0_RESET = mmu_pkg::K0_CACHED_DEFAULT
) (
    input  logic              aclk,
    input  logic              aresetn,

    // instruction path
    input  mmu_pkg::vaddr_t   i_vaddr,
    output mmu_pkg::paddr_t   i_paddr,

    // data path
    input  mmu_pkg::vaddr_t   d_vaddr,
    output mmu_pkg::paddr_t   d_paddr,
    output logic              d_uncached,

    // operation port for the K0 field
    input  logic              tu_op_we,
    input  mmu_pkg::k0_t      tu_op_k0,
    output mmu_pkg::k0_t      tu_op_k0_q
);

    mmu_pkg::k0_t k0;
    mmu_pkg::seg_t d_seg;

    // fixed mapping, kseg0 and kseg1 lose their top three bits
    function automatic mmu_pkg::paddr_t seg_map(input mmu_pkg::vaddr_t vaddr);
        mmu_pkg::seg_t seg;
        seg = vaddr[31:29];
        if (seg == mmu_pkg::SEG_KSEG0 || seg == mmu_pkg::SEG_KSEG1) begin
            return {3'b000, vaddr[28:0]};
        end
        return vaddr;  // kuseg and kseg2/3 pass unchanged
    endfunction

    assign i_paddr = seg_map(i_vaddr);
    assign d_paddr = seg_map(d_vaddr);

    assign d_seg = d_vaddr[31:29];

    // kseg1 never cached, kseg0 follows K0
    always_comb begin
        d_uncached = 1'b0;
        if (d_seg == mmu_pkg::SEG_KSEG1) begin
            d_uncached = 1'b1;
        end else if (d_seg == mmu_pkg::SEG_KSEG0) begin
            d_uncached = (k0 == mmu_pkg::K0_UNCACHED);
        end
    end

    // K0 register, a write shows up after the next edge
    always_ff @(posedge aclk) begin
        if (aresetn) begin
            k0 <= K0_RESET;
        end else if (tu_op_we) begin
            k0 <= tu_op_k0;
        end
    end

    assign tu_op_k0_q = k0;

endmodule

/* hdl/dbus_dispatch.sv */
`timescale 1ns/10ps

module dbus_dispatch (
    input  logic              aclk,
    input  logic              aresetn,

    // core data side, address already translated
    input  logic              dmem_req,
    input  logic              dmem_we,
    input  mmu_pkg::strb_t    dmem_wstrb,
    input  mmu_pkg::word_t    dmem_wdata,
    input  mmu_pkg::paddr_t   d_paddr,
    input  logic              d_uncached,
    output logic              dmem_addr_ok,
    output logic              dmem_data_ok,
    output mmu_pkg::word_t    dmem_rdata,

    // data cache port
    output logic              dcache_req,
    output logic              dcache_we,
    output mmu_pkg::paddr_t   dcache_addr,
    output mmu_pkg::strb_t    dcache_wstrb,
    output mmu_pkg::word_t    dcache_wdata,
    input  logic              dcache_addr_ok,
    input  logic              dcache_data_ok,
    input  mmu_pkg::word_t    dcache_rdata,

    // uncached port
    output logic              unc_req,
    output logic              unc_we,
    output mmu_pkg::paddr_t   unc_addr,
    output mmu_pkg::strb_t    unc_wstrb,
    output mmu_pkg::word_t    unc_wdata,
    input  logic              unc_addr_ok,
    input  logic              unc_data_ok,
    input  mmu_pkg::word_t    unc_rdata
);

    logic cur_finished;    // stage one already has addr_ok from its target
    logic last_finished;   // stage two has seen its data_ok
    logic last_uncached;   // stage two waits on the uncached port

    logic can_issue;
    logic issue;
    logic tgt_addr_ok;
    logic resp_sel;        // 1 selects the uncached response
    logic last_ready;
    logic cur_ready;

    // a second target may only start once stage two is empty,
    // otherwise its data_ok could overtake the older access
    assign can_issue = last_finished || (d_uncached == last_uncached);
    assign issue     = dmem_req && !cur_finished && can_issue;

    assign dcache_req = issue && !d_uncached;
    assign unc_req    = issue && d_uncached;

    // payload goes to both ports, only req tells them apart
    assign dcache_we    = dmem_we;
    assign dcache_addr  = d_paddr;
    assign dcache_wstrb = dmem_wstrb;
    assign dcache_wdata = dmem_wdata;
    assign unc_we       = dmem_we;
    assign unc_addr     = d_paddr;
    assign unc_wstrb    = dmem_wstrb;
    assign unc_wdata    = dmem_wdata;

    assign tgt_addr_ok = d_uncached ? unc_addr_ok : dcache_addr_ok;

    // with stage two empty, a return can only be the same-cycle data_ok
    // of the access being accepted now
    assign resp_sel     = last_finished ? d_uncached : last_uncached;
    assign dmem_data_ok = resp_sel ? unc_data_ok : dcache_data_ok;
    assign dmem_rdata   = resp_sel ? unc_rdata : dcache_rdata;

    assign last_ready   = last_finished || dmem_data_ok;
    assign cur_ready    = last_ready && (cur_finished || (issue && tgt_addr_ok));
    assign dmem_addr_ok = dmem_req && cur_ready;

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            cur_finished  <= 1'b0;
            last_finished <= 1'b1;
            last_uncached <= 1'b0;
        end else if (dmem_addr_ok) begin
            // stage one moves into stage two
            cur_finished  <= 1'b0;
            last_finished <= last_finished && dmem_data_ok;
            last_uncached <= d_uncached;
        end else begin
            if (issue && tgt_addr_ok) begin
                cur_finished <= 1'b1;   // hold off req, stage two still busy
            end
            if (!last_finished) begin
                last_finished <= dmem_data_ok;
            end
        end
    end

endmodule

/* hdl/mmu.sv */
`timescale 1ns/10ps

module mmu #(
    parameter mmu_pkg::k0_t K0_RESET = mmu_pkg::K0_CACHED_DEFAULT
) (
    input  logic              aclk,
    input  logic              aresetn,

    // translation unit operation port
    input  logic              tu_op_we,
    input  mmu_pkg::k0_t      tu_op_k0,
    output mmu_pkg::k0_t      tu_op_k0_q,

    // core instruction bus
    input  logic              imem_req,
    input  mmu_pkg::vaddr_t   imem_addr,
    output logic              imem_addr_ok,
    output logic              imem_data_ok,
    output mmu_pkg::word_t    imem_rdata,

    // core data bus
    input  logic              dmem_req,
    input  logic              dmem_we,
    input  mmu_pkg::vaddr_t   dmem_addr,
    input  mmu_pkg::strb_t    dmem_wstrb,
    input  mmu_pkg::word_t    dmem_wdata,
    output logic              dmem_addr_ok,
    output logic              dmem_data_ok,
    output mmu_pkg::word_t    dmem_rdata,

    // instruction cache port
    output logic              icache_req,
    output mmu_pkg::paddr_t   icache_addr,
    input  logic              icache_addr_ok,
    input  logic              icache_data_ok,
    input  mmu_pkg::word_t    icache_rdata,

    // data cache port
    output logic              dcache_req,
    output logic              dcache_we,
    output mmu_pkg::paddr_t   dcache_addr,
    output mmu_pkg::strb_t    dcache_wstrb,
    output mmu_pkg::word_t    dcache_wdata,
    input  logic              dcache_addr_ok,
    input  logic              dcache_data_ok,
    input  mmu_pkg::word_t    dcache_rdata,

    // uncached port
    output logic              unc_req,
    output logic              unc_we,
    output mmu_pkg::paddr_t   unc_addr,
    output mmu_pkg::strb_t    unc_wstrb,
    output mmu_pkg::word_t    unc_wdata,
    input  logic              unc_addr_ok,
    input  logic              unc_data_ok,
    input  mmu_pkg::word_t    unc_rdata
);

    mmu_pkg::paddr_t i_paddr;
    mmu_pkg::paddr_t d_paddr;
    logic            d_uncached;

    // fetches always use the icache, uncached segments included
    assign icache_req   = imem_req;
    assign icache_addr  = i_paddr;
    assign imem_addr_ok = icache_addr_ok;
    assign imem_data_ok = icache_data_ok;
    assign imem_rdata   = icache_rdata;

    addr_translate #(
        .K0_RESET   (K0_RESET)
    ) u_translate (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_vaddr    (imem_addr),
        .i_paddr    (i_paddr),
        .d_vaddr    (dmem_addr),
        .d_paddr    (d_paddr),
        .d_uncached (d_uncached),
        .tu_op_we   (tu_op_we),
        .tu_op_k0   (tu_op_k0),
        .tu_op_k0_q (tu_op_k0_q)
    );

    dbus_dispatch u_dispatch (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .dmem_req       (dmem_req),
        .dmem_we        (dmem_we),
        .dmem_wstrb     (dmem_wstrb),
        .dmem_wdata     (dmem_wdata),
        .d_paddr        (d_paddr),
        .d_uncached     (d_uncached),
        .dmem_addr_ok   (dmem_addr_ok),
        .dmem_data_ok   (dmem_data_ok),
        .dmem_rdata     (dmem_rdata),
        .dcache_req     (dcache_req),
        .dcache_we      (dcache_we),
        .dcache_addr    (dcache_addr),
        .dcache_wstrb   (dcache_wstrb),
        .dcache_wdata   (dcache_wdata),
        .dcache_addr_ok (dcache_addr_ok),
        .dcache_data_ok (dcache_data_ok),
        .dcache_rdata   (dcache_rdata),
        .unc_req        (unc_req),
        .unc_we         (unc_we),
        .unc_addr       (unc_addr),
        .unc_wstrb      (unc_wstrb),
        .unc_wdata      (unc_wdata),
        .unc_addr_ok    (unc_addr_ok),
        .unc_data_ok    (unc_data_ok),
        .unc_rdata      (unc_rdata)
    );

endmodule

/* tb/mem_target.sv */
`timescale 1ns/10ps

module mem_target #(
    parameter mmu_pkg::word_t TAG  = 32'h0,
    parameter integer         SEED = 1
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             req,
    input  logic             we,
    input  mmu_pkg::word_t   addr,
    input  mmu_pkg::strb_t   wstrb,
    input  mmu_pkg::word_t   wdata,
    output logic             addr_ok,
    output logic             data_ok,
    output mmu_pkg::word_t   rdata
);

    mmu_pkg::word_t mem [mmu_pkg::word_t];  // only written words live here
    mmu_pkg::word_t q_rdata [$];            // read data owed, in order
    mmu_pkg::word_t cur_rdata;
    logic [1:0]     a_cnt;                  // cycles left before addr_ok
    logic [1:0]     d_cnt;                  // cycles left before next data_ok
    logic           direct;
    integer         q_len = 0;              // queue length as seen by the outputs
    integer         seed = SEED;

    function automatic logic [1:0] rand_delay();
        integer r;
        r = $random(seed);
        return r[1:0];
    endfunction

    function automatic mmu_pkg::word_t read_word(input mmu_pkg::word_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ TAG;
    endfunction

    assign addr_ok = req && (a_cnt == 2'd0);
    assign direct  = (q_len == 0);  // nothing queued, may answer in the accept cycle

    always_comb begin
        cur_rdata = read_word(addr);
        if (direct) begin
            data_ok = addr_ok && (d_cnt == 2'd0);
            rdata   = cur_rdata;
        end else begin
            data_ok = (d_cnt == 2'd0);
            rdata   = q_rdata[0];
        end
    end

    always @(posedge aclk) begin
        logic fire;
        logic was_direct;
        mmu_pkg::word_t w;
        fire = data_ok;
        was_direct = direct;
        if (aresetn) begin
            q_rdata.delete();
            a_cnt <= rand_delay();
            d_cnt <= rand_delay();
        end else begin
            if (fire && !was_direct) begin
                void'(q_rdata.pop_front());
            end
            if (addr_ok) begin
                if (we) begin
                    w = read_word(addr);
                    for (int i = 0; i < 4; i++) begin
                        if (wstrb[i]) w[8*i +: 8] = wdata[8*i +: 8];
                    end
                    mem[addr] = w;
                end
                if (!(was_direct && fire)) begin
                    q_rdata.push_back(cur_rdata);
                end
                a_cnt <= rand_delay();
            end else if (req && a_cnt != 2'd0) begin
                a_cnt <= a_cnt - 2'd1;
            end
            if (fire) begin
                d_cnt <= rand_delay();
            end else if (d_cnt != 2'd0 && (!was_direct || addr_ok)) begin
                d_cnt <= d_cnt - 2'd1;
            end
        end
        q_len <= q_rdata.size();
    end

endmodule

/* tb/mmu_chk.sv */
`timescale 1ns/10ps

module mmu_chk (
    input logic             aclk,
    input logic             aresetn,
    input logic             dmem_req,
    input mmu_pkg::vaddr_t  dmem_addr,
    input logic             dmem_addr_ok,
    input logic             dmem_data_ok,
    input logic             dcache_req,
    input mmu_pkg::paddr_t  dcache_addr,
    input logic             dcache_addr_ok,
    input logic             unc_req,
    input mmu_pkg::paddr_t  unc_addr,
    input logic             unc_addr_ok
);

    logic [2:0] outstanding;  // accepted minus returned on the core side

    always_ff @(posedge aclk) begin
        if (aresetn) begin
            outstanding <= 3'd0;
        end else if ((dmem_req && dmem_addr_ok) && !dmem_data_ok) begin
            outstanding <= outstanding + 3'd1;
        end else if (!(dmem_req && dmem_addr_ok) && dmem_data_ok) begin
            outstanding <= outstanding - 3'd1;
        end
    end

    a_one_target: assert property (@(posedge aclk) disable iff (aresetn)
        !(dcache_req && unc_req)) else $error("dcache_req and unc_req high together");

    a_no_stray_data: assert property (@(posedge aclk) disable iff (aresetn)
        dmem_data_ok |-> (outstanding != 3'd0 || (dmem_req && dmem_addr_ok)))
        else $error("dmem_data_ok without an outstanding access");

    a_core_hold: assert property (@(posedge aclk) disable iff (aresetn)
        (dmem_req && !dmem_addr_ok) |=> (dmem_req && $stable(dmem_addr)))
        else $error("core request changed before dmem_addr_ok");

    a_dcache_hold: assert property (@(posedge aclk) disable iff (aresetn)
        (dcache_req && !dcache_addr_ok) |=> (dcache_req && $stable(dcache_addr)))
        else $error("dcache request changed before dcache_addr_ok");

    a_unc_hold: assert property (@(posedge aclk) disable iff (aresetn)
        (unc_req && !unc_addr_ok) |=> (unc_req && $stable(unc_addr)))
        else $error("uncached request changed before unc_addr_ok");

endmodule

bind mmu mmu_chk chk (
    .aclk(aclk), .aresetn(aresetn), .dmem_req(dmem_req), .dmem_addr(dmem_addr),
    .dmem_addr_ok(dmem_addr_ok), .dmem_data_ok(dmem_data_ok),
    .dcache_req(dcache_req), .dcache_addr(dcache_addr), .dcache_addr_ok(dcache_addr_ok),
    .unc_req(unc_req), .unc_addr(unc_addr), .unc_addr_ok(unc_addr_ok)
);

/* tb/mmu_tb.sv */
`timescale 1ns/10ps

module mmu_tb;

    localparam integer SEED = 41097;
    localparam mmu_pkg::word_t ITAG = 32'h1c1c_0000;
    localparam mmu_pkg::word_t DTAG = 32'hd0d0_0000;
    localparam mmu_pkg::word_t UTAG = 32'h5a5a_0000;

    logic aclk, aresetn;
    logic tu_op_we;
    mmu_pkg::k0_t tu_op_k0, tu_op_k0_q;
    logic imem_req, imem_addr_ok, imem_data_ok;
    mmu_pkg::vaddr_t imem_addr;
    mmu_pkg::word_t imem_rdata;
    logic dmem_req, dmem_we, dmem_addr_ok, dmem_data_ok;
    mmu_pkg::vaddr_t dmem_addr;
    mmu_pkg::strb_t dmem_wstrb;
    mmu_pkg::word_t dmem_wdata, dmem_rdata;
    logic icache_req, icache_addr_ok, icache_data_ok;
    mmu_pkg::paddr_t icache_addr;
    mmu_pkg::word_t icache_rdata;
    logic dcache_req, dcache_we, dcache_addr_ok, dcache_data_ok;
    mmu_pkg::paddr_t dcache_addr;
    mmu_pkg::strb_t dcache_wstrb;
    mmu_pkg::word_t dcache_wdata, dcache_rdata;
    logic unc_req, unc_we, unc_addr_ok, unc_data_ok;
    mmu_pkg::paddr_t unc_addr;
    mmu_pkg::strb_t unc_wstrb;
    mmu_pkg::word_t unc_wdata, unc_rdata;

    integer seed = SEED;
    integer errors = 0;
    integer checks = 0;
    integer accepted = 0;
    integer returned = 0;
    mmu_pkg::k0_t k0_ref = mmu_pkg::K0_CACHED_DEFAULT;
    mmu_pkg::word_t dc_model [mmu_pkg::paddr_t];
    mmu_pkg::word_t un_model [mmu_pkg::paddr_t];
    mmu_pkg::word_t exp_data [$];
    logic exp_read [$];
    string exp_name [$];

    mmu DUT (.*);

    mem_target #(.TAG(ITAG), .SEED(SEED + 1)) icache_mem (
        .aclk(aclk), .aresetn(aresetn), .req(icache_req), .we(1'b0), .addr(icache_addr),
        .wstrb(4'h0), .wdata(32'h0), .addr_ok(icache_addr_ok), .data_ok(icache_data_ok),
        .rdata(icache_rdata));
    mem_target #(.TAG(DTAG), .SEED(SEED + 2)) dcache_mem (
        .aclk(aclk), .aresetn(aresetn), .req(dcache_req), .we(dcache_we), .addr(dcache_addr),
        .wstrb(dcache_wstrb), .wdata(dcache_wdata), .addr_ok(dcache_addr_ok),
        .data_ok(dcache_data_ok), .rdata(dcache_rdata));
    mem_target #(.TAG(UTAG), .SEED(SEED + 3)) unc_mem (
        .aclk(aclk), .aresetn(aresetn), .req(unc_req), .we(unc_we), .addr(unc_addr),
        .wstrb(unc_wstrb), .wdata(unc_wdata), .addr_ok(unc_addr_ok),
        .data_ok(unc_data_ok), .rdata(unc_rdata));

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // {uncached, paddr} from the segment rules
    function automatic logic [32:0] ref_route(input mmu_pkg::vaddr_t va, input mmu_pkg::k0_t k0);
        logic unc;
        mmu_pkg::paddr_t pa;
        pa = va;
        unc = 1'b0;
        if (va[31:29] == mmu_pkg::SEG_KSEG0) begin
            pa[31:29] = 3'b000;
            unc = (k0 == mmu_pkg::K0_UNCACHED);
        end else if (va[31:29] == mmu_pkg::SEG_KSEG1) begin
            pa[31:29] = 3'b000;
            unc = 1'b1;
        end
        return {unc, pa};
    endfunction

    function automatic mmu_pkg::word_t model_read(input logic unc, input mmu_pkg::paddr_t pa);
        if (unc) return un_model.exists(pa) ? un_model[pa] : (pa ^ UTAG);
        return dc_model.exists(pa) ? dc_model[pa] : (pa ^ DTAG);
    endfunction

    task automatic model_write(input logic unc, input mmu_pkg::paddr_t pa,
                               input mmu_pkg::word_t wd, input mmu_pkg::strb_t strb);
        mmu_pkg::word_t w;
        w = model_read(unc, pa);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) w[8*i +: 8] = wd[8*i +: 8];
        end
        if (unc) un_model[pa] = w;
        else dc_model[pa] = w;
    endtask

    task automatic timeout_fail(input string name, input string what);
        $display("timeout in %s while waiting for %s", name, what);
        errors++;
    endtask

    // drives one access and returns once it is accepted, dmem_req stays high
    task automatic data_access(input string name, input logic we, input mmu_pkg::vaddr_t va,
                               input mmu_pkg::strb_t strb, input mmu_pkg::word_t wd);
        logic [32:0] r;
        integer t;
        r = ref_route(va, k0_ref);
        exp_read.push_back(!we);
        exp_name.push_back(name);
        exp_data.push_back(model_read(r[32], r[31:0]));
        if (we) model_write(r[32], r[31:0], wd, strb);
        @(posedge aclk);
        dmem_req <= 1'b1;
        dmem_we <= we;
        dmem_addr <= va;
        dmem_wstrb <= strb;
        dmem_wdata <= wd;
        t = 0;
        @(negedge aclk);
        while (!dmem_addr_ok) begin
            t++;
            if (t > 50) begin
                timeout_fail(name, "dmem_addr_ok");
                break;
            end
            @(negedge aclk);
        end
    endtask

    task automatic drain(input string name);
        integer t;
        @(posedge aclk);
        dmem_req <= 1'b0;
        t = 0;
        while (exp_data.size() != 0) begin
            t++;
            if (t > 50) begin
                timeout_fail(name, "outstanding dmem_data_ok");
                break;
            end
            @(negedge aclk);
        end
    endtask

    task automatic fetch(input string name, input mmu_pkg::vaddr_t va);
        logic [32:0] r;
        mmu_pkg::word_t expv;
        integer t;
        r = ref_route(va, k0_ref);
        expv = r[31:0] ^ ITAG;
        @(posedge aclk);
        imem_req <= 1'b1;
        imem_addr <= va;
        t = 0;
        @(negedge aclk);
        while (!imem_addr_ok) begin
            t++;
            if (t > 50) begin
                timeout_fail(name, "imem_addr_ok");
                break;
            end
            @(negedge aclk);
        end
        if (!imem_data_ok) begin
            @(posedge aclk);
            imem_req <= 1'b0;
            t = 0;
            @(negedge aclk);
            while (!imem_data_ok) begin
                t++;
                if (t > 50) begin
                    timeout_fail(name, "imem_data_ok");
                    break;
                end
                @(negedge aclk);
            end
        end
        checks++;
        if (imem_rdata !== expv) begin
            $display("FAILED %s expected %h actual %h", name, expv, imem_rdata);
            errors++;
        end
        @(posedge aclk);
        imem_req <= 1'b0;
    endtask

    task automatic set_k0(input mmu_pkg::k0_t v);
        @(posedge aclk);
        tu_op_we <= 1'b1;
        tu_op_k0 <= v;
        @(posedge aclk);
        tu_op_we <= 1'b0;
        k0_ref = v;
        @(negedge aclk);
        checks++;
        if (tu_op_k0_q !== v) begin
            $display("FAILED k0_write expected %h actual %h", v, tu_op_k0_q);
            errors++;
        end
    endtask

    function automatic mmu_pkg::vaddr_t rand_vaddr();
        integer r;
        integer s;
        logic [2:0] seg;
        r = $random(seed);
        s = $random(seed);
        seg = (s[1:0] == 2'd0) ? mmu_pkg::SEG_KSEG0 :
              (s[1:0] == 2'd1) ? mmu_pkg::SEG_KSEG1 : 3'b000;
        return {seg, 17'h0, r[9:0], 2'b00};
    endfunction

    task automatic report(input string name, input integer err_before);
        if (errors == err_before) $display("test %s ok", name);
        else $display("test %s had %0d errors", name, errors - err_before);
    endtask

    // target-side acceptances, a request issued twice shows up here
    always @(negedge aclk) begin
        if (!aresetn) begin
            if (dcache_req && dcache_addr_ok) accepted++;
            if (unc_req && unc_addr_ok) accepted++;
        end
    end

    // compares every core-side return against the head of the expected queue
    always @(negedge aclk) begin
        if (!aresetn && dmem_data_ok) begin
            if (exp_data.size() == 0) begin
                $display("dmem_data_ok came with no access outstanding");
                errors++;
            end else begin
                returned++;
                if (exp_read[0]) begin
                    checks++;
                    if (dmem_rdata !== exp_data[0]) begin
                        $display("FAILED %s expected %h actual %h", exp_name[0], exp_data[0],
                                 dmem_rdata);
                        errors++;
                    end
                end
                void'(exp_data.pop_front());
                void'(exp_read.pop_front());
                void'(exp_name.pop_front());
            end
        end
    end

    initial begin
        integer e;
        integer acc0;
        integer r;
        mmu_pkg::vaddr_t wa [8];
        aresetn = 1'b1;
        tu_op_we = 1'b0;
        tu_op_k0 = 3'd0;
        imem_req = 1'b0;
        imem_addr = 32'h0;
        dmem_req = 1'b0;
        dmem_we = 1'b0;
        dmem_addr = 32'h0;
        dmem_wstrb = 4'h0;
        dmem_wdata = 32'h0;
        repeat (8) @(posedge aclk);
        aresetn <= 1'b0;

        e = errors;
        for (int i = 0; i < 4; i++) data_access("kseg0_read", 1'b0, 32'h8000_0100 + 4 * i, 4'h0, 0);
        drain("kseg0_read");
        report("kseg0_read", e);

        e = errors;
        data_access("kseg1_kuseg", 1'b0, 32'ha000_0200, 4'h0, 0);
        data_access("kseg1_kuseg", 1'b0, 32'h0000_0300, 4'h0, 0);
        data_access("kseg1_kuseg", 1'b0, 32'h1234_5670, 4'h0, 0);
        data_access("kseg1_kuseg", 1'b0, 32'hbfff_fffc, 4'h0, 0);
        drain("kseg1_kuseg");
        report("kseg1_kuseg", e);

        e = errors;
        set_k0(mmu_pkg::K0_UNCACHED);
        data_access("k0_uncached", 1'b0, 32'h8000_0400, 4'h0, 0);
        data_access("k0_uncached", 1'b0, 32'h9000_0404, 4'h0, 0);
        drain("k0_uncached");
        set_k0(mmu_pkg::K0_CACHED_DEFAULT);
        data_access("k0_uncached", 1'b0, 32'h8000_0400, 4'h0, 0);
        drain("k0_uncached");
        report("k0_uncached", e);

        e = errors;
        acc0 = accepted;
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            data_access("random_burst", r[0], rand_vaddr(), r[7:4], $random(seed));
        end
        drain("random_burst");
        if (accepted - acc0 != 200) begin
            $display("random_burst counted %0d target acceptances instead of 200",
                     accepted - acc0);
            errors++;
        end
        report("random_burst", e);

        e = errors;
        for (int i = 0; i < 8; i++) begin
            wa[i] = rand_vaddr();
            r = $random(seed);
            data_access("write_merge", 1'b1, wa[i], r[3:0], $random(seed));
        end
        for (int i = 0; i < 8; i++) data_access("write_merge", 1'b0, wa[i], 4'h0, 0);
        drain("write_merge");
        report("write_merge", e);

        e = errors;
        fetch("fetch", 32'h8000_1000);
        fetch("fetch", 32'ha000_2004);
        fetch("fetch", 32'h0040_0008);
        report("fetch", e);

        $display("checks %0d errors %0d accepted %0d returned %0d", checks, errors, accepted,
                 returned);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/mmu_pkg.sv
hdl/addr_translate.sv
hdl/dbus_dispatch.sv
hdl/mmu.sv
tb/mem_target.sv
tb/mmu_chk.sv
tb/mmu_tb.sv

/* Makefile */
SIM  = obj_dir/Vmmu_tb
SRCS = $(wildcard hdl/*.sv tb/*.sv)

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --top-module mmu_tb -Mdir obj_dir -f compile.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "Done: no errors"

clean:
	rm -rf obj_dir

.PHONY: run clean
